// File: Bender.yml
package:
  name: afu_summer

sources:
  - afu_pkg.sv
  - wed_control.sv
  - array_summer.sv
  - command_arbiter.sv
  - response_router.sv
  - afu_top.sv
  - target: test
    files:
      - tb_host_model.sv
      - tb_afu.sv

// File: afu_pkg.sv
`default_nettype none

package afu_pkg;

  //////////////////////////////
  // Host command bus
  //////////////////////////////

  localparam int ADDR_WIDTH       = 64;
  localparam int CMD_SIZE_WIDTH   = 12;
  localparam int WRITE_ADDR_WIDTH = 6;
  localparam int LINE_BYTES       = 128; // Size of every read command
  localparam int HALF_BITS        = 512; // One buffer write

  typedef enum logic [12:0] {
    INVALID    = 13'h0000,
    READ_CL_NA = 13'h0A00
  } cmd_code_t;

  typedef enum logic [7:0] {
    DONE    = 8'h00,
    AERROR  = 8'h01,
    DERROR  = 8'h03,
    NLOCK   = 8'h04,
    NRES    = 8'h05,
    FLUSHED = 8'h06,
    FAULT   = 8'h07,
    FAILED  = 8'h08,
    PAGED   = 8'h0A
  } resp_code_t;

  //////////////////////////////
  // Tags
  //////////////////////////////

  localparam int TAG_WIDTH     = 8;
  localparam int OWNER_WIDTH   = 2;                       // Top bits of the tag
  localparam int LOW_TAG_WIDTH = TAG_WIDTH - OWNER_WIDTH; // Free for the owner

  localparam logic [OWNER_WIDTH-1:0] OWNER_WED    = 2'd0;
  localparam logic [OWNER_WIDTH-1:0] OWNER_SUMMER = 2'd1;
  localparam logic [TAG_WIDTH-1:0]   WED_TAG      = {OWNER_WED, 6'd0};

  //////////////////////////////
  // WED layout and job
  //////////////////////////////

  localparam int COUNT_WIDTH        = 32;
  localparam int WED_ARRAY_ADDR_MSB = 0;  // Big-endian bit numbering
  localparam int WED_ARRAY_ADDR_LSB = 63;
  localparam int WED_LINE_COUNT_MSB = 64;
  localparam int WED_LINE_COUNT_LSB = 95;

  localparam int MAX_IN_FLIGHT   = 4;
  localparam int IN_FLIGHT_WIDTH = $clog2(MAX_IN_FLIGHT + 1);
  localparam int ELEM_BITS       = 32;
  localparam int ELEMS_PER_HALF  = HALF_BITS / ELEM_BITS;

  typedef enum logic [2:0] {
    WED_RESET,
    WED_IDLE,
    WED_REQ,
    WED_WAIT,
    WED_DONE,
    WED_ERROR
  } wed_state_t;

endpackage

`default_nettype wire

// File: afu_top.sv
`timescale 1ns/1ps
`default_nettype none

module afu_top import afu_pkg::*; (
  input  logic                        clock,
  input  logic                        rstn,
  input  logic                        enabled,
  input  logic [0:ADDR_WIDTH-1]       wed_address,
  input  logic                        command_alfull,
  output logic                        command_valid,
  output cmd_code_t                   command_code,
  output logic [0:ADDR_WIDTH-1]       command_address,
  output logic [CMD_SIZE_WIDTH-1:0]   command_size,
  output logic [TAG_WIDTH-1:0]        command_tag,
  input  logic                        write_valid,
  input  logic [TAG_WIDTH-1:0]        write_tag,
  input  logic [WRITE_ADDR_WIDTH-1:0] write_address,
  input  logic [0:HALF_BITS-1]        write_data,
  input  logic                        response_valid,
  input  logic [TAG_WIDTH-1:0]        response_tag,
  input  resp_code_t                  response_code,
  output logic                        job_done,
  output logic [ELEM_BITS-1:0]        job_sum,
  output logic                        job_error
);

  logic                       wed_req, wed_issued, sum_req, sum_issued;
  logic [0:ADDR_WIDTH-1]      wed_req_address, sum_req_address, job_array_address;
  logic [TAG_WIDTH-1:0]       wed_req_tag, sum_req_tag;
  logic                       wed_write_valid, wed_write_half, sum_write_valid, sum_write_half;
  logic [0:HALF_BITS-1]       wed_write_data, sum_write_data;
  logic                       wed_response_valid, wed_response_ok;
  logic                       sum_response_valid, sum_response_ok;
  logic [LOW_TAG_WIDTH-1:0]   sum_response_low_tag;
  logic                       job_valid, wed_job_error, sum_job_error;
  logic [0:COUNT_WIDTH-1]     job_line_count;

  assign job_error = wed_job_error | sum_job_error;

  wed_control u_wed_control (
    .clock, .rstn, .enabled, .wed_address,
    .req (wed_req), .req_address (wed_req_address), .req_tag (wed_req_tag),
    .issued (wed_issued),
    .write_valid (wed_write_valid), .write_half (wed_write_half),
    .write_data (wed_write_data),
    .response_valid (wed_response_valid), .response_ok (wed_response_ok),
    .job_valid, .job_array_address, .job_line_count,
    .job_error (wed_job_error)
  );

  array_summer u_array_summer (
    .clock, .rstn, .job_valid, .job_array_address, .job_line_count,
    .req (sum_req), .req_address (sum_req_address), .req_tag (sum_req_tag),
    .issued (sum_issued),
    .write_valid (sum_write_valid), .write_half (sum_write_half),
    .write_data (sum_write_data),
    .response_valid (sum_response_valid), .response_ok (sum_response_ok),
    .response_low_tag (sum_response_low_tag),
    .job_done, .job_sum, .job_error (sum_job_error)
  );

  command_arbiter u_command_arbiter (
    .clock, .rstn, .command_alfull,
    .req_0 (wed_req), .req_address_0 (wed_req_address), .req_tag_0 (wed_req_tag),
    .issued_0 (wed_issued),
    .req_1 (sum_req), .req_address_1 (sum_req_address), .req_tag_1 (sum_req_tag),
    .issued_1 (sum_issued),
    .command_valid, .command_code, .command_address, .command_size, .command_tag
  );

  response_router u_response_router (
    .clock, .rstn, .write_valid, .write_tag, .write_address, .write_data,
    .response_valid, .response_tag, .response_code,
    .wed_write_valid, .wed_write_half, .wed_write_data,
    .wed_response_valid, .wed_response_ok, .wed_response_low_tag (),
    .sum_write_valid, .sum_write_half, .sum_write_data,
    .sum_response_valid, .sum_response_ok, .sum_response_low_tag
  );

endmodule

`default_nettype wire

// File: all.f
afu_pkg.sv
wed_control.sv
array_summer.sv
command_arbiter.sv
response_router.sv
afu_top.sv
tb_host_model.sv
tb_afu.sv

// File: array_summer.sv
`timescale 1ns/1ps
`default_nettype none

module array_summer import afu_pkg::*; (
  input  logic                     clock,
  input  logic                     rstn,
  input  logic                     job_valid,
  input  logic [0:ADDR_WIDTH-1]    job_array_address,
  input  logic [0:COUNT_WIDTH-1]   job_line_count,
  output logic                     req,
  output logic [0:ADDR_WIDTH-1]    req_address,
  output logic [TAG_WIDTH-1:0]     req_tag,
  input  logic                     issued,
  input  logic                     write_valid,
  input  logic                     write_half,
  input  logic [0:HALF_BITS-1]     write_data,
  input  logic                     response_valid,
  input  logic                     response_ok,
  input  logic [LOW_TAG_WIDTH-1:0] response_low_tag,
  output logic                     job_done,
  output logic [ELEM_BITS-1:0]     job_sum,
  output logic                     job_error
);

  logic                          job_valid_q;
  logic                          start, last_resp;
  logic                          active, pending, error;
  logic [IN_FLIGHT_WIDTH-1:0]    outstanding;
  logic [2**LOW_TAG_WIDTH-1:0]   in_flight;   // One bit per low tag
  logic [COUNT_WIDTH-1:0]        next_line, resp_lines, full_lines, line_count;
  logic [0:ADDR_WIDTH-1]         base_address;
  logic [ELEM_BITS-1:0]          half_sum;

  assign start     = job_valid && !job_valid_q;
  assign last_resp = active && response_valid && (resp_lines == line_count - 1'b1);

  //////////////////////////////
  // Read requests
  //////////////////////////////

  assign req = active && !pending && (next_line != line_count) &&
               (outstanding < MAX_IN_FLIGHT);
  assign req_address = base_address + ADDR_WIDTH'(next_line) * ADDR_WIDTH'(LINE_BYTES);
  assign req_tag     = {OWNER_SUMMER, next_line[LOW_TAG_WIDTH-1:0]};

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      job_valid_q <= 1'b0;
      active      <= 1'b0;
      pending     <= 1'b0;
      error       <= 1'b0;
      outstanding <= '0;
      in_flight   <= '0;
      next_line   <= '0;
      resp_lines  <= '0;
      job_done    <= 1'b0;
      job_error   <= 1'b0;
    end else begin
      job_valid_q <= job_valid;
      job_done    <= 1'b0;
      job_error   <= 1'b0;
      if (start) begin
        active      <= (job_line_count != '0);
        job_done    <= (job_line_count == '0); // Empty job ends at once
        pending     <= 1'b0;
        error       <= 1'b0;
        outstanding <= '0;
        in_flight   <= '0;
        next_line   <= '0;
        resp_lines  <= '0;
      end else if (active) begin
        if (req) begin
          pending   <= 1'b1;
          next_line <= next_line + 1'b1;
          in_flight[next_line[LOW_TAG_WIDTH-1:0]] <= 1'b1;
        end
        if (issued) pending <= 1'b0; // Peer may ask again
        outstanding <= outstanding + IN_FLIGHT_WIDTH'(req)
                                   - IN_FLIGHT_WIDTH'(response_valid);
        if (response_valid) begin
          resp_lines <= resp_lines + 1'b1;
          in_flight[response_low_tag] <= 1'b0;
          if (!response_ok) error <= 1'b1;
        end
        if (last_resp) begin
          active    <= 1'b0;
          job_done  <= 1'b1;
          job_error <= error || !response_ok;
        end
      end
    end
  end

  //////////////////////////////
  // Accumulate
  //////////////////////////////

  always_comb begin
    half_sum = '0;
    for (int i = 0; i < ELEMS_PER_HALF; i++) begin
      half_sum = half_sum + write_data[i*ELEM_BITS +: ELEM_BITS];
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      base_address <= job_array_address;
      line_count   <= job_line_count;
      job_sum      <= '0;
      full_lines   <= '0;
    end else if (active && write_valid) begin
      job_sum <= job_sum + half_sum; // Wraps modulo 2^32
      if (write_half) full_lines <= full_lines + 1'b1;
    end
  end

  assert property (@(posedge clock) disable iff (!rstn)
    outstanding <= MAX_IN_FLIGHT);

  // Every response retires a read that this unit has asked for
  assert property (@(posedge clock) disable iff (!rstn)
    active && response_valid |-> in_flight[response_low_tag]);

  // A clean job has seen both halves of every line
  assert property (@(posedge clock) disable iff (!rstn)
    job_done && !job_error |-> full_lines == line_count);

endmodule

`default_nettype wire

// File: command_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module command_arbiter import afu_pkg::*; (
  input  logic                      clock,
  input  logic                      rstn,
  input  logic                      command_alfull,
  input  logic                      req_0,
  input  logic [0:ADDR_WIDTH-1]     req_address_0,
  input  logic [TAG_WIDTH-1:0]      req_tag_0,
  output logic                      issued_0,
  input  logic                      req_1,
  input  logic [0:ADDR_WIDTH-1]     req_address_1,
  input  logic [TAG_WIDTH-1:0]      req_tag_1,
  output logic                      issued_1,
  output logic                      command_valid,
  output cmd_code_t                 command_code,
  output logic [0:ADDR_WIDTH-1]     command_address,
  output logic [CMD_SIZE_WIDTH-1:0] command_size,
  output logic [TAG_WIDTH-1:0]      command_tag
);

  logic [1:0]            req_in, pend, grant;
  logic                  last_grant;        // High when peer 1 won last
  logic [0:ADDR_WIDTH-1] slot_address [2];
  logic [TAG_WIDTH-1:0]  slot_tag [2];

  assign req_in = {req_1, req_0};

  //////////////////////////////
  // Slots
  //////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      pend       <= '0;
      last_grant <= 1'b0;
    end else begin
      pend <= (pend & ~grant) | req_in;
      if (command_valid) last_grant <= grant[1];
    end
  end

  always_ff @(posedge clock) begin
    if (req_0) begin
      slot_address[0] <= req_address_0;
      slot_tag[0]     <= req_tag_0;
    end
    if (req_1) begin
      slot_address[1] <= req_address_1;
      slot_tag[1]     <= req_tag_1;
    end
  end

  //////////////////////////////
  // Grant and command
  //////////////////////////////

  always_comb begin
    grant = pend;
    if (pend == 2'b11) grant = last_grant ? 2'b01 : 2'b10; // Alternate
    if (command_alfull) grant = 2'b00;                     // Hold everything
  end

  assign command_valid   = |grant;
  assign command_code    = command_valid ? READ_CL_NA : INVALID;
  assign command_address = grant[1] ? slot_address[1] : slot_address[0];
  assign command_tag     = grant[1] ? slot_tag[1] : slot_tag[0];
  assign command_size    = CMD_SIZE_WIDTH'(LINE_BYTES);
  assign issued_0        = grant[0];
  assign issued_1        = grant[1];

  // Peers wait for their issued pulse before asking again
  assert property (@(posedge clock) disable iff (!rstn) req_0 |-> !pend[0]);
  assert property (@(posedge clock) disable iff (!rstn) req_1 |-> !pend[1]);

endmodule

`default_nettype wire

// File: response_router.sv
`timescale 1ns/1ps
`default_nettype none

module response_router import afu_pkg::*; (
  input  logic                        clock,
  input  logic                        rstn,
  input  logic                        write_valid,
  input  logic [TAG_WIDTH-1:0]        write_tag,
  input  logic [WRITE_ADDR_WIDTH-1:0] write_address,
  input  logic [0:HALF_BITS-1]        write_data,
  input  logic                        response_valid,
  input  logic [TAG_WIDTH-1:0]        response_tag,
  input  resp_code_t                  response_code,
  output logic                        wed_write_valid,
  output logic                        wed_write_half,
  output logic [0:HALF_BITS-1]        wed_write_data,
  output logic                        wed_response_valid,
  output logic                        wed_response_ok,
  output logic [LOW_TAG_WIDTH-1:0]    wed_response_low_tag,
  output logic                        sum_write_valid,
  output logic                        sum_write_half,
  output logic [0:HALF_BITS-1]        sum_write_data,
  output logic                        sum_response_valid,
  output logic                        sum_response_ok,
  output logic [LOW_TAG_WIDTH-1:0]    sum_response_low_tag
);

  logic                   write_valid_q, response_valid_q, write_half_q;
  logic [TAG_WIDTH-1:0]   write_tag_q, response_tag_q;
  logic [0:HALF_BITS-1]   write_data_q;
  resp_code_t             response_code_q;
  logic [OWNER_WIDTH-1:0] write_owner, response_owner;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      write_valid_q    <= 1'b0;
      response_valid_q <= 1'b0;
    end else begin
      write_valid_q    <= write_valid;
      response_valid_q <= response_valid;
    end
  end

  always_ff @(posedge clock) begin
    write_tag_q     <= write_tag;
    write_half_q    <= write_address[0]; // Half index within the line
    write_data_q    <= write_data;
    response_tag_q  <= response_tag;
    response_code_q <= response_code;
  end

  assign write_owner    = write_tag_q[TAG_WIDTH-1 -: OWNER_WIDTH];
  assign response_owner = response_tag_q[TAG_WIDTH-1 -: OWNER_WIDTH];

  assign wed_write_valid      = write_valid_q && (write_owner == OWNER_WED);
  assign wed_write_half       = write_half_q;
  assign wed_write_data       = write_data_q;
  assign wed_response_valid   = response_valid_q && (response_owner == OWNER_WED);
  assign wed_response_ok      = (response_code_q == DONE);
  assign wed_response_low_tag = response_tag_q[LOW_TAG_WIDTH-1:0];

  assign sum_write_valid      = write_valid_q && (write_owner == OWNER_SUMMER);
  assign sum_write_half       = write_half_q;
  assign sum_write_data       = write_data_q;
  assign sum_response_valid   = response_valid_q && (response_owner == OWNER_SUMMER);
  assign sum_response_ok      = (response_code_q == DONE);
  assign sum_response_low_tag = response_tag_q[LOW_TAG_WIDTH-1:0];

endmodule

`default_nettype wire

// File: tb_afu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_afu import afu_pkg::*; ();

  localparam logic [31:0] SEED      = 32'h1f28586d;
  localparam int          TIMEOUT   = 4000; // Cycles allowed per job
  localparam int          MAX_LINES = 64;

  logic                        clock = 1'b0;
  logic                        rstn, enabled;
  logic [0:ADDR_WIDTH-1]       wed_address;
  logic                        command_alfull, command_valid;
  cmd_code_t                   command_code;
  logic [0:ADDR_WIDTH-1]       command_address;
  logic [CMD_SIZE_WIDTH-1:0]   command_size;
  logic [TAG_WIDTH-1:0]        command_tag, write_tag, response_tag;
  logic                        write_valid, response_valid;
  logic [WRITE_ADDR_WIDTH-1:0] write_address;
  logic [0:HALF_BITS-1]        write_data;
  resp_code_t                  response_code;
  logic                        job_done, job_error;
  logic [ELEM_BITS-1:0]        job_sum;
  logic [63:0]                 model_array_address, fail_line;
  logic [31:0]                 model_line_count;
  logic                        fail_enable, alfull_bursts;

  // Job table
  string       t_name [$];
  logic [63:0] t_wed [$];
  logic [63:0] t_array [$];
  int          t_count [$];
  int          t_fail [$];     // Failing line index or -1
  bit          t_fail_wed [$];
  bit          t_bursts [$];

  string       cur_name = "reset";
  logic [63:0] cur_wed, cur_array;
  int          cur_count = 0;
  bit          seen [MAX_LINES];
  int          wed_cmds = 0, array_cmds = 0, outstanding = 0, alfull_cycles = 0;
  int          errors = 0, passed = 0, failed = 0;
  bit          finished;

  always #10 clock = ~clock;

  afu_top dut (
    .clock, .rstn, .enabled, .wed_address, .command_alfull,
    .command_valid, .command_code, .command_address, .command_size, .command_tag,
    .write_valid, .write_tag, .write_address, .write_data,
    .response_valid, .response_tag, .response_code,
    .job_done, .job_sum, .job_error
  );

  tb_host_model host (
    .clock, .rstn, .command_valid, .command_address, .command_tag, .command_alfull,
    .write_valid, .write_tag, .write_address, .write_data,
    .response_valid, .response_tag, .response_code,
    .wed_address (wed_address), .wed_array_address (model_array_address),
    .wed_line_count (model_line_count), .fail_enable, .fail_line, .alfull_bursts
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] mem_word(input logic [63:0] address);
    return xorshift32(address[31:0] ^ address[63:32] ^ SEED);
  endfunction

  // Sum of every 32-bit element over the job's lines modulo 2^32
  function automatic logic [31:0] expected_sum(input logic [63:0] base, input int count);
    logic [31:0] sum;
    sum = '0;
    for (int line = 0; line < count; line++) begin
      for (int k = 0; k < LINE_BYTES / 4; k++) begin
        sum = sum + mem_word(base + 64'(line * LINE_BYTES + k * 4));
      end
    end
    return sum;
  endfunction

  task automatic add_row(input string name, input logic [63:0] wed, input logic [63:0] array,
                         input int count, input int fail, input bit fail_wed, input bit bursts);
    t_name.push_back(name);
    t_wed.push_back(wed);
    t_array.push_back(array);
    t_count.push_back(count);
    t_fail.push_back(fail);
    t_fail_wed.push_back(fail_wed);
    t_bursts.push_back(bursts);
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("ERROR %s %s expected %0h actual %0h", cur_name, what, expected, actual);
    errors++;
  endtask

  task automatic report_failure(input string text);
    $display("%s failed because %s", cur_name, text);
    errors++;
  endtask

  //////////////////////////////
  // Host bus monitor
  //////////////////////////////

  always @(posedge clock) begin
    logic [63:0] offset;
    int          line;
    if (rstn) begin
      if (command_alfull) alfull_cycles++;
      if (response_valid && response_tag[TAG_WIDTH-1 -: OWNER_WIDTH] == OWNER_SUMMER) begin
        outstanding--;
      end
      if (command_valid) begin
        if (command_alfull) report_failure("a command was issued while command_alfull was high");
        if (command_size !== LINE_BYTES) report_mismatch("command_size", LINE_BYTES, command_size);
        if (command_code !== READ_CL_NA) report_mismatch("command_code", READ_CL_NA, command_code);
        if (command_tag[TAG_WIDTH-1 -: OWNER_WIDTH] == OWNER_WED) begin
          wed_cmds++;
          if (command_tag !== WED_TAG) report_mismatch("WED read tag", WED_TAG, command_tag);
          if (command_address !== cur_wed) begin
            report_mismatch("WED read address", cur_wed, command_address);
          end
        end else if (command_tag[TAG_WIDTH-1 -: OWNER_WIDTH] == OWNER_SUMMER) begin
          outstanding++;
          array_cmds++;
          if (outstanding > MAX_IN_FLIGHT) begin
            report_mismatch("outstanding reads limit", MAX_IN_FLIGHT, outstanding);
          end
          offset = command_address - cur_array;
          line   = int'(offset / LINE_BYTES);
          if (offset % LINE_BYTES != 0 || offset >= 64'(cur_count) * LINE_BYTES) begin
            report_failure($sformatf("array read at %h lies outside the job", command_address));
          end else if (seen[line]) begin
            report_failure($sformatf("array line %0d was read twice", line));
          end else begin
            seen[line] = 1'b1;
            if (int'(command_tag[LOW_TAG_WIDTH-1:0]) != line % 64) begin
              report_mismatch("array read tag", line % 64, command_tag[LOW_TAG_WIDTH-1:0]);
            end
          end
        end else begin
          report_failure("a command carried an unknown owner in its tag");
        end
      end
    end
  end

  //////////////////////////////
  // One job
  //////////////////////////////

  task automatic run_job(input int t, output bit done_ok);
    int          wait_cycles;
    int          idle_cycles;
    int          errors_before;
    bit          expect_error;
    logic [31:0] sum;
    done_ok       = 1'b0;
    expect_error  = (t_fail[t] >= 0) || t_fail_wed[t];
    errors_before = errors;
    sum           = expected_sum(t_array[t], t_count[t]);
    @(negedge clock);
    cur_name  = t_name[t];
    cur_wed   = t_wed[t];
    cur_array = t_array[t];
    cur_count = t_count[t];
    for (int i = 0; i < MAX_LINES; i++) seen[i] = 1'b0;
    wed_cmds      = 0;
    array_cmds    = 0;
    alfull_cycles = 0;
    model_array_address = t_array[t];
    model_line_count    = t_count[t];
    fail_enable   = expect_error;
    fail_line     = t_fail_wed[t] ? t_wed[t] : t_array[t] + 64'(t_fail[t] * LINE_BYTES);
    alfull_bursts = t_bursts[t];
    wed_address   = t_wed[t];
    enabled       = 1'b1;
    wait_cycles   = 0;
    do begin
      @(negedge clock);
      wait_cycles++;
    end while (!job_done && !job_error && wait_cycles < TIMEOUT);
    if (!job_done && !job_error) begin
      report_failure("neither job_done nor job_error arrived before the timeout");
      $display("%s  FAIL  timed out", cur_name);
      failed++;
      return;
    end
    if (expect_error) begin
      if (job_error !== 1'b1) report_mismatch("job_error", 1, job_error);
    end else begin
      if (job_error !== 1'b0) report_mismatch("job_error", 0, job_error);
      if (job_sum !== sum) report_mismatch("job_sum", sum, job_sum);
    end
    enabled       = 1'b0;
    alfull_bursts = 1'b0;
    idle_cycles   = 0;
    do begin
      @(negedge clock);
      idle_cycles++;
    end while ((job_done || job_error) && idle_cycles < TIMEOUT);
    if (job_done || job_error) begin
      report_failure("job_done or job_error stayed high after enabled went low");
    end
    if (wed_cmds != 1) report_mismatch("WED reads", 1, wed_cmds);
    if (array_cmds != (t_fail_wed[t] ? 0 : t_count[t])) begin
      report_mismatch("array reads", t_fail_wed[t] ? 0 : t_count[t], array_cmds);
    end
    if (t_bursts[t] && alfull_cycles == 0) report_failure("command_alfull never went high");
    if (errors == errors_before) begin
      passed++;
      $display("%s  ok  sum %h  %0d cycles", cur_name, job_sum, wait_cycles);
    end else begin
      failed++;
      $display("%s  FAIL  %0d errors", cur_name, errors - errors_before);
    end
    done_ok = 1'b1;
  endtask

  initial begin
    rstn                = 1'b0;
    enabled             = 1'b0;
    wed_address         = '0;
    model_array_address = '0;
    model_line_count    = '0;
    fail_enable         = 1'b0;
    fail_line           = '0;
    alfull_bursts       = 1'b0;
    //      name             wed       array                   lines fail wed_f bursts
    add_row("single_line",   64'h1000, 64'h2_0000,             1,    -1,  0,    0);
    add_row("ten_lines",     64'h1080, 64'h4_0000,             10,   -1,  0,    0);
    add_row("zero_lines",    64'h2000, 64'h6_0000,             0,    -1,  0,    0);
    add_row("alfull_bursts", 64'h3000, 64'h8_0000,             12,   -1,  0,    1);
    add_row("forty_lines",   64'h4000, 64'h1_2345_6780,        40,   -1,  0,    0);
    add_row("line_fail",     64'h5000, 64'hA_0000,             8,    5,   0,    0);
    add_row("wed_fail",      64'h6000, 64'hC_0000,             4,    -1,  1,    0);
    repeat (8) @(posedge clock);
    @(negedge clock);
    rstn = 1'b1;
    for (int t = 0; t < t_name.size(); t++) begin
      run_job(t, finished);
      if (!finished) break;
    end
    $display("tests %0d  passed %0d  failed %0d  errors %0d",
             t_name.size(), passed, failed, errors);
    if (errors == 0 && failed == 0 && passed == t_name.size()) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_host_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_host_model import afu_pkg::*; (
  input  logic                        clock,
  input  logic                        rstn,
  input  logic                        command_valid,
  input  logic [0:ADDR_WIDTH-1]       command_address,
  input  logic [TAG_WIDTH-1:0]        command_tag,
  output logic                        command_alfull,
  output logic                        write_valid,
  output logic [TAG_WIDTH-1:0]        write_tag,
  output logic [WRITE_ADDR_WIDTH-1:0] write_address,
  output logic [0:HALF_BITS-1]        write_data,
  output logic                        response_valid,
  output logic [TAG_WIDTH-1:0]        response_tag,
  output resp_code_t                  response_code,
  input  logic [63:0]                 wed_address,       // Line that holds the WED
  input  logic [63:0]                 wed_array_address,
  input  logic [31:0]                 wed_line_count,
  input  logic                        fail_enable,
  input  logic [63:0]                 fail_line,         // Line answered with FAILED
  input  logic                        alfull_bursts
);

  localparam logic [31:0] SEED = 32'h1f28586d;

  logic [63:0]          pend_address [$];
  logic [TAG_WIDTH-1:0] pend_tag [$];
  int                   pend_ready [$];   // Cycle from which a read may be served
  logic [31:0]          rand_state = SEED;
  int                   cycle = 0;
  int                   burst_left = 0;
  int                   phase = 0;
  logic                 busy = 1'b0;
  logic [63:0]          cur_address;
  logic [TAG_WIDTH-1:0] cur_tag;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Memory word at a byte address, folded from all 64 address bits
  function automatic logic [31:0] mem_word(input logic [63:0] address);
    return xorshift32(address[31:0] ^ address[63:32] ^ SEED);
  endfunction

  function automatic logic [31:0] next_rand();
    rand_state = xorshift32(rand_state);
    return rand_state;
  endfunction

  function automatic logic [0:HALF_BITS-1] half_data(input logic [63:0] line, input int half);
    logic [0:HALF_BITS-1] data;
    for (int k = 0; k < ELEMS_PER_HALF; k++) begin
      data[k*ELEM_BITS +: ELEM_BITS] = mem_word(line + 64'(half * (HALF_BITS / 8) + k * 4));
    end
    if (line == wed_address && half == 0) begin
      data[WED_ARRAY_ADDR_MSB:WED_ARRAY_ADDR_LSB] = wed_array_address;
      data[WED_LINE_COUNT_MSB:WED_LINE_COUNT_LSB] = wed_line_count;
    end
    return data;
  endfunction

  initial begin
    command_alfull = 1'b0;
    write_valid    = 1'b0;
    write_tag      = '0;
    write_address  = '0;
    write_data     = '0;
    response_valid = 1'b0;
    response_tag   = '0;
    response_code  = DONE;
  end

  //////////////////////////////
  // Command capture
  //////////////////////////////

  always @(posedge clock) begin
    cycle <= cycle + 1;
    if (rstn && command_valid) begin
      pend_address.push_back(command_address);
      pend_tag.push_back(command_tag);
      pend_ready.push_back(cycle + int'(next_rand() & 32'd7)); // 0 to 7 cycles late
    end
  end

  //////////////////////////////
  // Data and responses
  //////////////////////////////

  always @(negedge clock) begin
    write_valid    <= 1'b0;
    response_valid <= 1'b0;
    if (!alfull_bursts) begin
      burst_left = 0;
    end else if (burst_left == 0 && (next_rand() & 32'd7) == 0) begin
      burst_left = 1 + int'(next_rand() & 32'd7); // Burst of 1 to 8 cycles
    end
    command_alfull <= (burst_left != 0);
    if (burst_left != 0) burst_left = burst_left - 1;

    if (!busy && pend_ready.size() != 0 && pend_ready[0] <= cycle) begin
      cur_address = pend_address.pop_front();
      cur_tag     = pend_tag.pop_front();
      void'(pend_ready.pop_front());
      busy  = 1'b1;
      phase = 0;
    end
    if (busy) begin
      if (phase < 2) begin
        write_valid   <= 1'b1; // Both halves go ahead of the response
        write_tag     <= cur_tag;
        write_address <= WRITE_ADDR_WIDTH'(phase);
        write_data    <= half_data(cur_address, phase);
      end else begin
        response_valid <= 1'b1;
        response_tag   <= cur_tag;
        response_code  <= (fail_enable && cur_address == fail_line) ? FAILED : DONE;
        busy = 1'b0;
      end
      phase = phase + 1;
    end
  end

endmodule

`default_nettype wire

// File: wed_control.sv
`timescale 1ns/1ps
`default_nettype none

module wed_control import afu_pkg::*; (
  input  logic                   clock,
  input  logic                   rstn,
  input  logic                   enabled,
  input  logic [0:ADDR_WIDTH-1]  wed_address,
  output logic                   req,
  output logic [0:ADDR_WIDTH-1]  req_address,
  output logic [TAG_WIDTH-1:0]   req_tag,
  input  logic                   issued,
  input  logic                   write_valid,
  input  logic                   write_half,
  input  logic [0:HALF_BITS-1]   write_data,
  input  logic                   response_valid,
  input  logic                   response_ok,
  output logic                   job_valid,
  output logic [0:ADDR_WIDTH-1]  job_array_address,
  output logic [0:COUNT_WIDTH-1] job_line_count,
  output logic                   job_error
);

  wed_state_t               state, next_state;
  logic [0:2*HALF_BITS-1]   wed_line;

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state <= WED_RESET;
      req   <= 1'b0;
    end else begin
      state <= next_state;
      req   <= (state == WED_IDLE) && enabled; // Single pulse on entry to REQ
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      WED_RESET: next_state = WED_IDLE;
      WED_IDLE: begin
        if (enabled) next_state = WED_REQ;
      end
      WED_REQ: begin
        if (issued) next_state = WED_WAIT; // Command is on the host bus
      end
      WED_WAIT: begin
        if (response_valid) next_state = response_ok ? WED_DONE : WED_ERROR;
      end
      WED_DONE, WED_ERROR: begin
        if (!enabled) next_state = WED_IDLE; // Job held until disabled
      end
      default: next_state = WED_RESET;
    endcase
  end

  assign req_address = wed_address;
  assign req_tag     = WED_TAG;
  assign job_valid   = (state == WED_DONE);
  assign job_error   = (state == WED_ERROR);

  //////////////////////////////
  // WED line and decode
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (write_valid && state == WED_WAIT) begin
      if (write_half) begin
        wed_line[HALF_BITS:2*HALF_BITS-1] <= write_data; // Second 64 bytes
      end else begin
        wed_line[0:HALF_BITS-1] <= write_data;
      end
    end
    // Both halves are in by the time the response arrives
    if (state == WED_WAIT && response_valid && response_ok) begin
      job_array_address <= wed_line[WED_ARRAY_ADDR_MSB:WED_ARRAY_ADDR_LSB];
      job_line_count    <= wed_line[WED_LINE_COUNT_MSB:WED_LINE_COUNT_LSB];
    end
  end

  // Host data for the WED tag only comes back while the read is open
  assert property (@(posedge clock) disable iff (!rstn)
    write_valid |-> state == WED_WAIT);

endmodule

`default_nettype wire
